/* dv/i2c_cases.txt */
# op(W/R) dev_addr reg_addr data exp_nack exp_data_reg (all hex)
# reads that nack keep the data column in the data register
W 6F 00 5A 0 5A
W 6F 01 C3 0 C3
W 6F FF 81 0 81
R 6F 01 00 0 C3
R 6F 00 11 0 5A
W 50 02 77 1 77
R 50 01 3C 1 3C
R 6F FF 00 0 81
W 6F 01 0F 0 0F
R 6F 01 EE 0 0F
W 6E 10 99 1 99
W 6F 80 A5 0 A5
R 6F 80 00 0 A5
R 37 80 22 1 22
W 6F 7E 00 0 00
R 6F 7E FF 0 00

/* dv/i2c_rtc_model.sv */
`timescale 1ns/1ns

module i2c_rtc_model (
  input  logic arst_n,
  input  logic scl,      // resolved lines
  input  logic sda,
  output logic sda_low   // open drain pull on sda
);

  localparam logic [6:0] DEV_ADDR = 7'h6F;
  localparam int M_IDLE  = 0;
  localparam int M_ADDR  = 1;
  localparam int M_REG   = 2;
  localparam int M_WDATA = 3;
  localparam int M_RDATA = 4; // target drives sda
  localparam int M_SKIP  = 5; // not addressed and waiting for start or stop

  logic [7:0] mem [256];
  int         mode = M_IDLE;
  int         next_mode = M_IDLE;
  int         bit_cnt = 0;
  logic [7:0] shreg = '0;
  logic [7:0] tx = '0;
  logic [7:0] ptr = '0;      // auto incrementing register pointer
  logic       ack_pend = 1'b0;
  logic       in_ack = 1'b0;
  logic       scl_q = 1'b1;
  logic       sda_q = 1'b1;

  // fill pattern over the whole address
  initial begin
    for (int i = 0; i < 256; i++) mem[i] = 8'(i * 7) ^ 8'h5A;
  end

  task load_tx();
    tx      = mem[ptr];
    ptr     = ptr + 8'd1;
    bit_cnt = 0;
    sda_low = ~tx[7]; // msb first
  endtask

  task take_byte();
    ack_pend = 1'b1;
    next_mode = M_WDATA;
    case (mode)
      M_ADDR: begin
        ack_pend = (shreg[7:1] == DEV_ADDR);
        if (!ack_pend) next_mode = M_SKIP;
        else if (shreg[0]) next_mode = M_RDATA;
        else next_mode = M_REG;
      end
      M_REG: ptr = shreg;
      default: begin
        mem[ptr] = shreg; // data byte lands here
        ptr      = ptr + 8'd1;
      end
    endcase
  endtask

  task rise_edge();
    if (mode == M_RDATA) begin
      if (bit_cnt < 8) bit_cnt++;
      else if (sda) mode = M_SKIP; // master nack ends the read
      else bit_cnt = 9;
    end else if (mode != M_IDLE && mode != M_SKIP && bit_cnt < 8) begin
      shreg = {shreg[6:0], sda};
      bit_cnt++;
      if (bit_cnt == 8) take_byte();
    end
  endtask

  task fall_edge();
    if (mode == M_RDATA) begin
      if (bit_cnt == 9) load_tx();       // master acked so next byte follows
      else if (bit_cnt == 8) sda_low = 1'b0; // master ack slot
      else sda_low = ~tx[3'(7 - bit_cnt)];
    end else if (in_ack) begin
      sda_low = 1'b0; // end of ack clock
      in_ack  = 1'b0;
      bit_cnt = 0;
      mode    = next_mode;
      if (mode == M_RDATA) load_tx();
    end else if (bit_cnt == 8 && mode != M_IDLE && mode != M_SKIP) begin
      in_ack  = 1'b1;
      sda_low = ack_pend;
    end
  endtask

  // one process sees every line change
  always @(scl or sda or arst_n) begin
    if (!arst_n) begin
      mode    = M_IDLE;
      in_ack  = 1'b0;
      sda_low = 1'b0;
    end else if (scl && scl_q && sda_q && !sda) begin // start or repeated start
      mode    = M_ADDR;
      bit_cnt = 0;
      in_ack  = 1'b0;
      sda_low = 1'b0;
    end else if (scl && scl_q && !sda_q && sda) begin // stop
      mode    = M_IDLE;
      sda_low = 1'b0;
    end else if (scl && !scl_q) begin
      rise_edge();
    end else if (!scl && scl_q) begin
      fall_edge();
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

/* dv/tb_i2c_master_8bit.sv */
`timescale 1ns/1ns

module tb_i2c_master_8bit;

  localparam int WAIT_LIMIT = 64 * 4 * int'(rtc_i2c_pkg::QUARTER_CYCLES);

  logic        clk;
  logic        arst_n;
  logic [1:0]  addr;
  logic [7:0]  di;
  logic        wr;
  logic [7:0]  rdata;
  logic        scl_low;
  logic        sda_low;
  logic        tgt_sda_low;
  logic        scl;
  logic        sda;
  logic [15:0] lfsr;

  assign scl = ~scl_low;                 // pull-up with only the host pulling scl low
  assign sda = ~(sda_low | tgt_sda_low); // wired and

  i2c_master_8bit dut_i (
    .clk(clk), .arst_n(arst_n), .addr(addr), .di(di), .wr(wr), .rdata(rdata),
    .scl_low(scl_low), .sda_low(sda_low), .scl_in(scl), .sda_in(sda)
  );

  i2c_rtc_model rtc_i (.arst_n(arst_n), .scl(scl), .sda(sda), .sda_low(tgt_sda_low));

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois form
  endfunction

  function automatic logic [7:0] draw_bits(int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %02h, expected %02h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic check_status(input rtc_i2c_pkg::i2c_status_t got,
                              input rtc_i2c_pkg::i2c_status_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: busy %b nack %b, expected busy %b nack %b",
               $time, what, got.busy, got.nack, exp.busy, exp.nack);
      $display("TEST FAIL");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic reg_write(input logic [1:0] a, input logic [7:0] d);
    @(negedge clk);
    addr = a;
    di   = d;
    wr   = 1'b1;
    @(negedge clk);
    wr   = 1'b0;
  endtask

  // rdata follows addr by one clock
  task automatic reg_read(input logic [1:0] a, output logic [7:0] v);
    @(negedge clk);
    addr = a;
    @(negedge clk);
    v = rdata;
  endtask

  task automatic read_status(output rtc_i2c_pkg::i2c_status_t st);
    logic [7:0] v;
    reg_read(rtc_i2c_pkg::REG_CTRL, v);
    check_byte(v & 8'hFC, 8'h00, "status upper bits");
    st = rtc_i2c_pkg::i2c_status_t'(v[1:0]);
  endtask

  task automatic wait_idle();
    rtc_i2c_pkg::i2c_status_t st;
    int n;
    n = 0;
    read_status(st);
    while (st.busy) begin
      n += 2; // two clocks per status poll
      if (n > WAIT_LIMIT) begin
        $display("timeout: the host stayed busy and the transaction never finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
      end
      read_status(st);
    end
  endtask

  task automatic run_case(input logic [7:0] op, input logic [7:0] dev, input logic [7:0] ra,
                          input logic [7:0] dat, input logic en, input logic [7:0] erd);
    rtc_i2c_pkg::i2c_status_t st;
    logic [7:0] v;
    reg_write(rtc_i2c_pkg::REG_DEV_ADDR, dev);
    reg_write(rtc_i2c_pkg::REG_REG_ADDR, ra);
    reg_write(rtc_i2c_pkg::REG_DATA, dat);
    reg_write(rtc_i2c_pkg::REG_CTRL, (op == "R") ? 8'h80 : 8'h00); // go
    wait_idle();
    read_status(st);
    check_status(st, '{nack: en, busy: 1'b0}, "status after transaction");
    reg_read(rtc_i2c_pkg::REG_DATA, v);
    check_byte(v, erd, "data register after transaction");
    if (op == "W" && !en) check_byte(rtc_i.mem[ra], dat, "target memory after write");
  endtask

  initial begin
    rtc_i2c_pkg::i2c_status_t st;
    logic [7:0] v;
    logic [7:0] vals [3];
    logic [7:0] op;
    logic [7:0] dev;
    logic [7:0] ra;
    logic [7:0] dat;
    logic [7:0] en;
    logic [7:0] erd;
    string      line;
    int         fd;
    int         n;
    addr   = '0;
    di     = '0;
    wr     = 1'b0;
    arst_n = 1'b1;
    lfsr   = 16'd9832;
    #1 arst_n = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // idle after reset with both lines released
    read_status(st);
    check_status(st, '{nack: 1'b0, busy: 1'b0}, "status after reset");
    check_byte({6'd0, scl_low, sda_low}, 8'h00, "pin drive after reset");

    // plain register readback without any control write
    for (int i = 0; i < 3; i++) begin
      vals[i] = draw_bits(8);
      reg_write(2'(i), vals[i]);
    end
    for (int i = 0; i < 3; i++) begin
      reg_read(2'(i), v);
      check_byte(v, vals[i], "register readback");
    end

    fd = $fopen("dv/i2c_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file dv/i2c_cases.txt");
      $display("TEST FAIL");
      $fatal(1, "no case file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue; // comment or blank
      n = $sscanf(line, "%c %h %h %h %h %h", op, dev, ra, dat, en, erd);
      if (n != 6) begin
        $display("malformed line in the case file: %s", line);
        $display("TEST FAIL");
        $fatal(1, "bad case line");
      end
      run_case(op, dev, ra, dat, en[0], erd);
      repeat (draw_bits(4)) @(negedge clk); // idle gap 0..15
    end
    $fclose(fd);

    // second control write during a transfer gets dropped
    reg_write(rtc_i2c_pkg::REG_DEV_ADDR, 8'h6F);
    reg_write(rtc_i2c_pkg::REG_REG_ADDR, 8'h42);
    reg_write(rtc_i2c_pkg::REG_DATA, 8'h3C);
    reg_write(rtc_i2c_pkg::REG_CTRL, 8'h00);
    read_status(st);
    check_status(st, '{nack: 1'b0, busy: 1'b1}, "busy during write");
    reg_write(rtc_i2c_pkg::REG_REG_ADDR, 8'h00); // register 00 holds another byte
    reg_write(rtc_i2c_pkg::REG_CTRL, 8'h80); // read request that must be ignored
    wait_idle();
    repeat (4 * int'(rtc_i2c_pkg::QUARTER_CYCLES)) @(negedge clk);
    read_status(st);
    check_status(st, '{nack: 1'b0, busy: 1'b0}, "no second transaction");
    reg_read(rtc_i2c_pkg::REG_DATA, v);
    check_byte(v, 8'h3C, "data register after dropped start");
    check_byte(rtc_i.mem[8'h42], 8'h3C, "target memory after dropped start");

    $display("TEST PASS");
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run from the project root
rm -f sim.log
verilator --binary --timing -f tb.f --top-module tb_i2c_master_8bit -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ns

module i2c_bit_engine (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      cmd_valid,
  input  rtc_i2c_pkg::i2c_bit_cmd_t cmd,
  output logic                      bit_done,
  output logic                      rx_bit,
  output logic                      scl_low,
  output logic                      sda_low,
  input  logic                      sda_in,
  input  logic                      scl_in
);

  logic [1:0]               sync_q1;  // {scl, sda}
  logic [1:0]               sync_q2;
  logic                     scl_sync;
  logic                     sda_sync;
  logic                     active;
  logic [1:0]               phase;    // quarter of the scl period
  logic [15:0]              cnt;
  rtc_i2c_pkg::i2c_bit_op_e op_q;
  logic                     bit_q;

  assign scl_sync = sync_q2[1];
  assign sda_sync = sync_q2[0];

  // pin drive {scl_low, sda_low} for one quarter
  function automatic logic [1:0] drive(rtc_i2c_pkg::i2c_bit_op_e op, logic v,
                                       logic [1:0] ph, logic [1:0] cur);
    logic sda_d;
    sda_d = (op == rtc_i2c_pkg::BIT_WRITE) ? ~v : 1'b0; // read releases sda
    case (op)
      rtc_i2c_pkg::BIT_START:
        case (ph)
          2'd0:    return {cur[1], 1'b0}; // release sda and keep scl
          2'd1:    return 2'b00;          // both high
          2'd2:    return 2'b01;          // sda falls while scl high
          default: return 2'b11;
        endcase
      rtc_i2c_pkg::BIT_STOP:
        case (ph)
          2'd0:    return 2'b11;
          2'd1:    return 2'b01;          // scl up with sda held low
          default: return 2'b00;          // sda rises to leave the bus idle
        endcase
      default:
        // data changes only while scl is low
        return {(ph == 2'd0 || ph == 2'd3), sda_d};
    endcase
  endfunction

  // 2-flop sync on the resolved lines
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= 2'b11; // pulled up
      sync_q2 <= 2'b11;
    end else begin
      sync_q1 <= {scl_in, sda_in};
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active   <= 1'b0;
      phase    <= '0;
      cnt      <= '0;
      op_q     <= rtc_i2c_pkg::BIT_START;
      bit_q    <= 1'b0;
      bit_done <= 1'b0;
      rx_bit   <= 1'b0;
      scl_low  <= 1'b0;
      sda_low  <= 1'b0;
    end else begin
      bit_done <= 1'b0;
      if (!active) begin
        if (cmd_valid) begin
          active  <= 1'b1;
          op_q    <= cmd.op;
          bit_q   <= cmd.bit_value;
          phase   <= 2'd0;
          cnt     <= 16'd1; // strobe cycle counts toward quarter 0
          {scl_low, sda_low} <= drive(cmd.op, cmd.bit_value, 2'd0, {scl_low, sda_low});
        end
      end else if (cnt != rtc_i2c_pkg::QUARTER_CYCLES - 16'd1) begin
        cnt <= cnt + 16'd1;
      end else if (phase != 2'd1 || scl_sync) begin // hold until scl really high
        cnt <= '0;
        if (phase == 2'd3) begin
          active   <= 1'b0;
          bit_done <= 1'b1; // pins stay as left by quarter 3
        end else begin
          phase <= phase + 2'd1;
          {scl_low, sda_low} <= drive(op_q, bit_q, phase + 2'd1, {scl_low, sda_low});
          if (phase == 2'd1) rx_bit <= sda_sync; // middle of scl high
        end
      end
    end
  end

endmodule

/* source/i2c_byte_sequencer.sv */
`timescale 1ns/1ns

module i2c_byte_sequencer (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      start,
  input  rtc_i2c_pkg::i2c_request_t req,
  output logic                      done,
  output rtc_i2c_pkg::i2c_result_t  result,
  output logic                      cmd_valid,
  output rtc_i2c_pkg::i2c_bit_cmd_t cmd,
  input  logic                      bit_done,
  input  logic                      rx_bit
);

  typedef enum logic [3:0] {
    S_IDLE, S_START, S_ADDR, S_ADDR_ACK, S_REG, S_REG_ACK, S_WDATA, S_WDATA_ACK,
    S_RSTART, S_RADDR, S_RADDR_ACK, S_RDATA, S_MNACK, S_STOP
  } state_e;

  state_e                    state;
  rtc_i2c_pkg::i2c_request_t req_q;
  logic [7:0]                shreg;     // tx bits left aligned and rx shifting in at lsb
  logic [2:0]                bit_cnt;   // bits still to go after current one
  logic                      nack_q;
  logic [7:0]                next_byte; // byte to load on leaving current state

  function automatic rtc_i2c_pkg::i2c_bit_cmd_t mk_cmd(rtc_i2c_pkg::i2c_bit_op_e op,
                                                       logic v);
    return '{op: op, bit_value: v};
  endfunction

  always_comb begin
    case (state)
      S_START:    next_byte = {req_q.dev_addr, 1'b0}; // address + W
      S_ADDR_ACK: next_byte = req_q.reg_addr;
      S_REG_ACK:  next_byte = req_q.wr_data;
      default:    next_byte = {req_q.dev_addr, 1'b1}; // address + R after repeated start
    endcase
  end

  always_ff @(posedge clk) begin
    if (start && state == S_IDLE) req_q <= req;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      shreg     <= '0;
      bit_cnt   <= '0;
      nack_q    <= 1'b0;
      cmd_valid <= 1'b0;
      cmd       <= '0;
      done      <= 1'b0;
      result    <= '0;
    end else begin
      cmd_valid <= 1'b0;
      done      <= 1'b0;
      case (state)
        S_IDLE: if (start) begin
          nack_q    <= 1'b0;
          cmd       <= mk_cmd(rtc_i2c_pkg::BIT_START, 1'b0);
          cmd_valid <= 1'b1;
          state     <= S_START;
        end
        S_START, S_RSTART: if (bit_done) begin // load address byte
          cmd       <= mk_cmd(rtc_i2c_pkg::BIT_WRITE, next_byte[7]);
          cmd_valid <= 1'b1;
          shreg     <= {next_byte[6:0], 1'b0};
          bit_cnt   <= 3'd7;
          state     <= (state == S_START) ? S_ADDR : S_RADDR;
        end
        S_ADDR, S_REG, S_WDATA, S_RADDR: if (bit_done) begin
          cmd_valid <= 1'b1;
          if (bit_cnt != 3'd0) begin
            cmd     <= mk_cmd(rtc_i2c_pkg::BIT_WRITE, shreg[7]); // msb first
            shreg   <= {shreg[6:0], 1'b0};
            bit_cnt <= bit_cnt - 3'd1;
          end else begin
            cmd <= mk_cmd(rtc_i2c_pkg::BIT_READ, 1'b0); // ack slot from target
            case (state)
              S_ADDR:  state <= S_ADDR_ACK;
              S_REG:   state <= S_REG_ACK;
              S_WDATA: state <= S_WDATA_ACK;
              default: state <= S_RADDR_ACK;
            endcase
          end
        end
        S_ADDR_ACK, S_REG_ACK, S_WDATA_ACK, S_RADDR_ACK: if (bit_done) begin
          cmd_valid <= 1'b1;
          if (rx_bit || state == S_WDATA_ACK) begin
            nack_q <= rx_bit; // high ack means nobody answered
            cmd    <= mk_cmd(rtc_i2c_pkg::BIT_STOP, 1'b0);
            state  <= S_STOP;
          end else if (state == S_RADDR_ACK) begin
            cmd     <= mk_cmd(rtc_i2c_pkg::BIT_READ, 1'b0);
            bit_cnt <= 3'd7;
            state   <= S_RDATA;
          end else if (state == S_REG_ACK && req_q.read) begin
            cmd   <= mk_cmd(rtc_i2c_pkg::BIT_START, 1'b0); // repeated start
            state <= S_RSTART;
          end else begin
            cmd     <= mk_cmd(rtc_i2c_pkg::BIT_WRITE, next_byte[7]);
            shreg   <= {next_byte[6:0], 1'b0};
            bit_cnt <= 3'd7;
            state   <= (state == S_ADDR_ACK) ? S_REG : S_WDATA;
          end
        end
        S_RDATA: if (bit_done) begin
          cmd_valid <= 1'b1;
          shreg     <= {shreg[6:0], rx_bit};
          if (bit_cnt != 3'd0) begin
            cmd     <= mk_cmd(rtc_i2c_pkg::BIT_READ, 1'b0);
            bit_cnt <= bit_cnt - 3'd1;
          end else begin
            cmd   <= mk_cmd(rtc_i2c_pkg::BIT_WRITE, 1'b1); // master nack on the last byte
            state <= S_MNACK;
          end
        end
        S_MNACK: if (bit_done) begin
          cmd       <= mk_cmd(rtc_i2c_pkg::BIT_STOP, 1'b0);
          cmd_valid <= 1'b1;
          state     <= S_STOP;
        end
        default: if (bit_done) begin // S_STOP
          done   <= 1'b1;
          result <= '{rd_data: shreg, nack: nack_q};
          state  <= S_IDLE;
        end
      endcase
    end
  end

endmodule

/* source/i2c_host_regs.sv */
`timescale 1ns/1ns

module i2c_host_regs (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [1:0]                addr,
  input  logic [7:0]                di,
  input  logic                      wr,
  output logic [7:0]                rdata,
  output logic                      start,
  output rtc_i2c_pkg::i2c_request_t req,
  input  logic                      done,
  input  rtc_i2c_pkg::i2c_result_t  result
);

  logic [7:0] data_q;    // write byte or read result
  logic [7:0] reg_addr_q;
  logic [7:0] dev_addr_q;
  logic       busy;
  logic       nack_q;
  logic       ctrl_go;   // accepted control write
  rtc_i2c_pkg::i2c_status_t status;

  assign ctrl_go = wr && (addr == rtc_i2c_pkg::REG_CTRL) && !busy; // dropped while busy
  assign status  = '{nack: nack_q, busy: busy};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_q     <= '0;
      reg_addr_q <= '0;
      dev_addr_q <= '0;
      busy       <= 1'b0;
      nack_q     <= 1'b0;
      start      <= 1'b0;
      rdata      <= '0;
    end else begin
      start <= ctrl_go; // one cycle pulse
      if (ctrl_go) busy <= 1'b1;
      if (wr) begin
        case (addr)
          rtc_i2c_pkg::REG_DATA:     data_q     <= di;
          rtc_i2c_pkg::REG_REG_ADDR: reg_addr_q <= di;
          rtc_i2c_pkg::REG_DEV_ADDR: dev_addr_q <= di;
          default: ;                 // control handled by ctrl_go
        endcase
      end
      if (done) begin
        busy   <= 1'b0;
        nack_q <= result.nack;
        // only a clean read brings back a byte
        if (req.read && !result.nack) data_q <= result.rd_data;
      end
      // read mux registered one cycle behind addr
      case (addr)
        rtc_i2c_pkg::REG_DATA:     rdata <= data_q;
        rtc_i2c_pkg::REG_REG_ADDR: rdata <= reg_addr_q;
        rtc_i2c_pkg::REG_DEV_ADDR: rdata <= dev_addr_q;
        default:                   rdata <= {6'd0, status};
      endcase
    end
  end

  // request snapshot held for the whole transaction
  always_ff @(posedge clk) begin
    if (ctrl_go) req <= '{read: di[7], dev_addr: dev_addr_q[6:0],
                          reg_addr: reg_addr_q, wr_data: data_q};
  end

endmodule

/* source/i2c_master_8bit.sv */
`timescale 1ns/1ns

module i2c_master_8bit (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [1:0] addr,
  input  logic [7:0] di,
  input  logic       wr,
  output logic [7:0] rdata,
  output logic       scl_low,  // open drain enables
  output logic       sda_low,
  input  logic       scl_in,   // resolved line levels
  input  logic       sda_in
);

  logic                      start;
  logic                      done;
  rtc_i2c_pkg::i2c_request_t req;
  rtc_i2c_pkg::i2c_result_t  result;
  logic                      cmd_valid;
  rtc_i2c_pkg::i2c_bit_cmd_t cmd;
  logic                      bit_done;
  logic                      rx_bit;

  // host side registers
  i2c_host_regs regs_i (
    .clk(clk), .arst_n(arst_n), .addr(addr), .di(di), .wr(wr), .rdata(rdata),
    .start(start), .req(req), .done(done), .result(result)
  );

  // byte level transaction fsm
  i2c_byte_sequencer seq_i (
    .clk(clk), .arst_n(arst_n), .start(start), .req(req), .done(done),
    .result(result), .cmd_valid(cmd_valid), .cmd(cmd), .bit_done(bit_done),
    .rx_bit(rx_bit)
  );

  // scl/sda waveforms
  i2c_bit_engine bit_i (
    .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd(cmd),
    .bit_done(bit_done), .rx_bit(rx_bit), .scl_low(scl_low), .sda_low(sda_low),
    .sda_in(sda_in), .scl_in(scl_in)
  );

endmodule

/* source/rtc_i2c_pkg.sv */
package rtc_i2c_pkg;

  // host register map
  localparam logic [1:0] REG_DATA     = 2'd0; // write byte / last read byte
  localparam logic [1:0] REG_REG_ADDR = 2'd1; // device register pointer
  localparam logic [1:0] REG_DEV_ADDR = 2'd2; // 7-bit i2c address in [6:0]
  localparam logic [1:0] REG_CTRL     = 2'd3; // bit 7 read/write, status on read

  // clocks per quarter scl period
  localparam logic [15:0] QUARTER_CYCLES = 16'd8;

  // one transaction as launched by a control write
  typedef struct packed {
    logic       read;     // 1 read, 0 write
    logic [6:0] dev_addr;
    logic [7:0] reg_addr;
    logic [7:0] wr_data;
  } i2c_request_t;

  // returned with done
  typedef struct packed {
    logic [7:0] rd_data;
    logic       nack;     // some byte was not acked
  } i2c_result_t;

  // nack first so busy lands on bit 0 of the status byte
  typedef struct packed {
    logic nack;
    logic busy;
  } i2c_status_t;

  // bit level symbols
  typedef enum logic [1:0] {
    BIT_START,
    BIT_STOP,
    BIT_WRITE,
    BIT_READ
  } i2c_bit_op_e;

  typedef struct packed {
    i2c_bit_op_e op;
    logic        bit_value; // sda level for BIT_WRITE
  } i2c_bit_cmd_t;

endpackage

/* tb.f */
source/rtc_i2c_pkg.sv
source/i2c_host_regs.sv
source/i2c_byte_sequencer.sv
source/i2c_bit_engine.sv
source/i2c_master_8bit.sv
dv/i2c_rtc_model.sv
dv/tb_i2c_master_8bit.sv
